//--- source/rom_loader_defines.svh
// ROM loader shared constants

`ifndef ROM_LOADER_DEFINES_SVH
`define ROM_LOADER_DEFINES_SVH

////////////////////////////////
// Widths
////////////////////////////////

// Memory address seen by the memory controller
`define ADDR_W 23

// Byte offset inside one 16 KiB page
`define OFFSET_W 14

// Page number, top bit marks an upper ROM page
`define PAGE_W 9

// Download address coming from the host
`define HOST_ADDR_W 25

// Number of upper ROM slots tracked for the CPU side
`define UPPER_PAGES 256

////////////////////////////////
// Fixed pages
////////////////////////////////

`define PAGE_OS_LOW 9'h000  // OS, lower ROM
`define PAGE_BASIC  9'h100  // BASIC, upper slot 0
`define PAGE_AMSDOS 9'h107  // Disk ROM, upper slot 7
`define PAGE_TOP    9'h1FF  // Last upper page
`define PAGE_UNUSED 9'h1EE  // Parking page for bad extensions

////////////////////////////////
// Limits
////////////////////////////////

// 16 KiB blocks accepted from the system ROM image
`define SYS_BLOCKS 8

`endif

//--- source/rom_loader_pkg.sv
// ROM loader shared types

`include "rom_loader_defines.svh"

package rom_loader_pkg;

	////////////////////////////////
	// Addressing
	////////////////////////////////

	// Bit PAGE_W-1 set means an upper ROM page
	typedef logic [`PAGE_W-1:0] page_t;

	// Page number above, byte offset below
	typedef logic [`ADDR_W-1:0] mem_addr_t;

	////////////////////////////////
	// Payloads
	////////////////////////////////

	// One byte write into memory
	typedef struct packed {
		mem_addr_t   addr;
		logic [1:0]  bank;  // Model bank for expansions
		logic [7:0]  data;
	} mem_req_t;

	// Two ASCII characters of the file extension
	typedef struct packed {
		logic [7:0] hi;  // First character, upper nibble
		logic [7:0] lo;  // Second character, lower nibble
	} file_ext_t;

endpackage

//--- source/ext_page_decode.sv
// Extension to base page decoder

`include "rom_loader_defines.svh"

module ext_page_decode (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     download,
	input  logic [7:0]               ioctl_index,
	input  rom_loader_pkg::file_ext_t file_ext,
	input  logic                     commit,
	input  rom_loader_pkg::mem_req_t committed,
	output rom_loader_pkg::page_t    base_page
);

	logic                  download_d;
	logic                  combo;       // Z0 file, jump pending
	logic [4:0]            hi_nib;      // {valid, nibble}
	logic [4:0]            lo_nib;
	rom_loader_pkg::page_t ext_page;
	logic                  ext_combo;
	logic                  last_offset;

	// One ASCII character as a hex digit, bit 4 flags a valid digit
	function automatic logic [4:0] hex_digit(input logic [7:0] ch);
		logic [4:0] res;
		res = '0;
		if (ch >= "0" && ch <= "9")
			res = {1'b1, ch[3:0]};
		else if (ch >= "A" && ch <= "F")
			res = {1'b1, ch[3:0] + 4'd9};
		return res;
	endfunction

	////////////////////////////////
	// Decode
	////////////////////////////////

	always_comb begin
		hi_nib    = hex_digit(file_ext.hi);
		lo_nib    = hex_digit(file_ext.lo);
		ext_page  = `PAGE_UNUSED;  // Bad digits keep their nibble from here
		ext_combo = 1'b0;
		if (hi_nib[4]) ext_page[7:4] = hi_nib[3:0];
		if (lo_nib[4]) ext_page[3:0] = lo_nib[3:0];
		if (file_ext == "ZZ") ext_page = `PAGE_OS_LOW;
		if (file_ext == "Z0") begin
			ext_page  = `PAGE_OS_LOW;
			ext_combo = 1'b1;
		end
	end

	assign last_offset = &committed.addr[`OFFSET_W-1:0];

	////////////////////////////////
	// Page register
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			combo      <= 1'b0;
			base_page  <= `PAGE_OS_LOW;
		end else begin
			download_d <= download;
			// Combo file moves on after the last byte of its first page
			if (commit && combo && last_offset) begin
				combo     <= 1'b0;
				base_page <= `PAGE_TOP;
			end
			if (download && !download_d && (|ioctl_index)) begin
				base_page <= ext_page;
				combo     <= ext_combo;
			end
		end
	end

endmodule

//--- source/boot_addr_map.sv
// Download byte address mapper

`include "rom_loader_defines.svh"

module boot_addr_map (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     download,
	input  logic                     ioctl_wr,
	input  logic [`HOST_ADDR_W-1:0]  ioctl_addr,
	input  logic [7:0]               ioctl_dout,
	input  logic [7:0]               ioctl_index,
	input  rom_loader_pkg::page_t    base_page,
	input  logic                     model,
	output logic                     req_valid,
	output rom_loader_pkg::mem_req_t req
);

	logic [`HOST_ADDR_W-`OFFSET_W-1:0] block;  // 16 KiB block of the file
	logic [7:0]                        page_low;
	rom_loader_pkg::page_t             sys_page;
	logic                              sys_ok;
	logic                              is_ext;
	logic                              accept;
	rom_loader_pkg::mem_req_t          next_req;

	assign block    = ioctl_addr[`HOST_ADDR_W-1:`OFFSET_W];
	assign page_low = base_page[7:0] + ioctl_addr[`OFFSET_W+7:`OFFSET_W];  // Wraps at 256
	assign is_ext   = |ioctl_index;
	assign sys_ok   = (block < `SYS_BLOCKS);

	////////////////////////////////
	// System ROM layout
	////////////////////////////////

	// Blocks n and n+4 share a page, bank picks the model
	always_comb begin
		case (block[1:0])
			2'd0:    sys_page = `PAGE_OS_LOW;
			2'd1:    sys_page = `PAGE_BASIC;
			2'd2:    sys_page = `PAGE_AMSDOS;
			default: sys_page = `PAGE_TOP;
		endcase
	end

	always_comb begin
		next_req.data                   = ioctl_dout;
		next_req.addr[`OFFSET_W-1:0]    = ioctl_addr[`OFFSET_W-1:0];
		if (is_ext) begin
			next_req.addr[`ADDR_W-1:`OFFSET_W] = {base_page[`PAGE_W-1], page_low};
			next_req.bank                      = {1'b0, model};
		end else begin
			next_req.addr[`ADDR_W-1:`OFFSET_W] = sys_page;
			next_req.bank                      = {1'b0, block[2]};
		end
	end

	// Bytes past the system blocks are dropped here
	assign accept = download & ioctl_wr & (is_ext | sys_ok);

	////////////////////////////////
	// Request register
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			req_valid <= 1'b0;
		else
			req_valid <= accept;
	end

	always_ff @(posedge clk_sys) begin
		if (accept) req <= next_req;
	end

endmodule

//--- source/boot_mem_writer.sv
// Boot write to memory at reference pace

module boot_mem_writer (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     req_valid,
	input  logic                     ref_strobe,
	input  rom_loader_pkg::mem_req_t req,
	output logic                     ioctl_wait,
	output logic                     mem_wr,
	output logic                     commit,
	output rom_loader_pkg::mem_req_t mem_req,
	output rom_loader_pkg::mem_req_t committed
);

	logic done;  // Second strobe with the write already issued

	assign done = ref_strobe & mem_wr & ioctl_wait;

	////////////////////////////////
	// Control
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait <= 1'b0;
			mem_wr     <= 1'b0;
			commit     <= 1'b0;
		end else begin
			commit <= done;
			if (ref_strobe) begin
				mem_wr <= ioctl_wait;  // Issue on the first strobe
				if (done) begin
					mem_wr     <= 1'b0;
					ioctl_wait <= 1'b0;
				end
			end
			// Host holds off while the byte is pending
			if (req_valid) ioctl_wait <= 1'b1;
		end
	end

	////////////////////////////////
	// Payload
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (req_valid) mem_req <= req;
		if (done) committed <= mem_req;  // Copy for the page and map trackers
	end

endmodule

//--- source/rom_map_table.sv
// Upper ROM presence map

`include "rom_loader_defines.svh"

module rom_map_table (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      model_sel,
	input  logic                      commit,
	input  rom_loader_pkg::mem_req_t  committed,
	input  rom_loader_pkg::mem_addr_t rd_addr,
	output logic                      model,
	output logic [7:0]                rom_mask
);

	logic [`UPPER_PAGES-1:0] rom_map;    // One bit per upper page
	logic                    model_chg;
	logic                    wr_upper;
	logic [7:0]              wr_page;
	logic                    rd_upper;
	logic [7:0]              rd_page;

	assign model_chg = reset & (model != model_sel);
	assign wr_upper  = committed.addr[`ADDR_W-1];
	assign wr_page   = committed.addr[`ADDR_W-2:`OFFSET_W];
	assign rd_upper  = rd_addr[`ADDR_W-1];
	assign rd_page   = rd_addr[`ADDR_W-2:`OFFSET_W];

	////////////////////////////////
	// Model latch
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) model <= model_sel;
	end

	////////////////////////////////
	// Map
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (model_chg) begin
			rom_map                 <= '0;
			rom_map[0]              <= 1'b1;  // BASIC
			rom_map[7]              <= 1'b1;  // Disk ROM
			rom_map[`UPPER_PAGES-1] <= 1'b1;
		end else if (commit && wr_upper) begin
			rom_map[wr_page] <= 1'b1;
		end
	end

	// Empty upper pages read back as FF
	assign rom_mask = (!rd_upper || rom_map[rd_page]) ? 8'h00 : 8'hFF;

endmodule

//--- source/rom_loader_top.sv
// ROM loader top level

`include "rom_loader_defines.svh"

module rom_loader_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      download,
	input  logic                      ioctl_wr,
	input  logic [`HOST_ADDR_W-1:0]   ioctl_addr,
	input  logic [7:0]                ioctl_dout,
	input  logic [7:0]                ioctl_index,
	input  rom_loader_pkg::file_ext_t file_ext,
	input  logic                      model_sel,
	input  logic                      ref_strobe,
	input  rom_loader_pkg::mem_addr_t rd_addr,
	output logic                      ioctl_wait,
	output logic                      mem_wr,
	output rom_loader_pkg::mem_req_t  mem_req,
	output logic [7:0]                rom_mask
);

	rom_loader_pkg::page_t    base_page;
	logic                     req_valid;
	rom_loader_pkg::mem_req_t req;
	logic                     commit;
	rom_loader_pkg::mem_req_t committed;
	logic                     model;

	////////////////////////////////
	// Address path
	////////////////////////////////

	ext_page_decode ext_page_decode_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download    (download),
		.ioctl_index (ioctl_index),
		.file_ext    (file_ext),
		.commit      (commit),
		.committed   (committed),
		.base_page   (base_page)
	);

	boot_addr_map boot_addr_map_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download    (download),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.ioctl_index (ioctl_index),
		.base_page   (base_page),
		.model       (model),
		.req_valid   (req_valid),
		.req         (req)
	);

	////////////////////////////////
	// Memory side
	////////////////////////////////

	boot_mem_writer boot_mem_writer_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.req_valid   (req_valid),
		.ref_strobe  (ref_strobe),
		.req         (req),
		.ioctl_wait  (ioctl_wait),
		.mem_wr      (mem_wr),
		.commit      (commit),
		.mem_req     (mem_req),
		.committed   (committed)
	);

	rom_map_table rom_map_table_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model_sel   (model_sel),
		.commit      (commit),
		.committed   (committed),
		.rd_addr     (rd_addr),
		.model       (model),
		.rom_mask    (rom_mask)
	);

endmodule

//--- sim/rom_loader_model.svh
// ROM loader reference model

`ifndef ROM_LOADER_MODEL_SVH
`define ROM_LOADER_MODEL_SVH

logic [255:0]          mdl_map;    // Expected upper ROM presence
logic                  mdl_model;  // Expected latched model
rom_loader_pkg::page_t mdl_base;
logic                  mdl_combo;  // Z0 jump still pending

// Value of one hex character, -1 for anything else
function automatic int hex_value(input logic [7:0] ch);
	if (ch >= "0" && ch <= "9")
		return {24'd0, ch} - 32'd48;
	if (ch >= "A" && ch <= "F")
		return {24'd0, ch} - 32'd55;
	return -1;
endfunction

// Base page taken when a download starts
task automatic mdl_start(input logic [7:0] index, input rom_loader_pkg::file_ext_t ext);
	int hi;
	int lo;
	hi = hex_value(ext.hi);
	lo = hex_value(ext.lo);
	if (index != 8'd0) begin
		mdl_base  = `PAGE_UNUSED;
		mdl_combo = 1'b0;
		if (hi >= 0) mdl_base[7:4] = hi[3:0];
		if (lo >= 0) mdl_base[3:0] = lo[3:0];
		if (ext == "ZZ") mdl_base = `PAGE_OS_LOW;
		if (ext == "Z0") begin
			mdl_base  = `PAGE_OS_LOW;
			mdl_combo = 1'b1;
		end
	end
endtask

// Write expected for one host byte, returns 0 when the byte is dropped
function automatic logic predict_req(input logic [24:0] addr, input logic [7:0] data,
		input logic [7:0] index, output rom_loader_pkg::mem_req_t exp);
	logic [10:0] block;
	block          = addr[24:14];
	exp.data       = data;
	exp.addr[13:0] = addr[13:0];
	if (index != 8'd0) begin
		exp.addr[22:14] = {mdl_base[8], mdl_base[7:0] + addr[21:14]};  // Block wraps the page
		exp.bank        = {1'b0, mdl_model};
		return 1'b1;
	end
	case (block[1:0])
		2'd0:    exp.addr[22:14] = `PAGE_OS_LOW;
		2'd1:    exp.addr[22:14] = `PAGE_BASIC;
		2'd2:    exp.addr[22:14] = `PAGE_AMSDOS;
		default: exp.addr[22:14] = `PAGE_TOP;
	endcase
	exp.bank = {1'b0, block[2]};  // Second model in blocks 4 to 7
	return block < 11'd8;
endfunction

task automatic mdl_commit(input rom_loader_pkg::mem_req_t req);
	if (req.addr[22]) mdl_map[req.addr[21:14]] = 1'b1;
	if (mdl_combo && (&req.addr[13:0])) begin
		mdl_base  = `PAGE_TOP;
		mdl_combo = 1'b0;
	end
endtask

// One clock of reset with the given model select
task automatic mdl_reset(input logic sel);
	if (mdl_model !== sel) begin
		mdl_map      = '0;
		mdl_map[0]   = 1'b1;
		mdl_map[7]   = 1'b1;
		mdl_map[255] = 1'b1;
	end
	mdl_model = sel;
	mdl_base  = `PAGE_OS_LOW;
	mdl_combo = 1'b0;
endtask

function automatic logic [7:0] expected_mask(input rom_loader_pkg::mem_addr_t rd);
	return (!rd[22] || mdl_map[rd[21:14]]) ? 8'h00 : 8'hFF;
endfunction

`endif

//--- sim/tb_rom_loader.sv
// ROM loader testbench

`include "rom_loader_defines.svh"

module tb_rom_loader;
	timeunit 1ns;
	timeprecision 1ps;

	logic                      clk_sys;
	logic                      reset;
	logic                      download;
	logic                      ioctl_wr;
	logic [`HOST_ADDR_W-1:0]   ioctl_addr;
	logic [7:0]                ioctl_dout;
	logic [7:0]                ioctl_index;
	rom_loader_pkg::file_ext_t file_ext;
	logic                      model_sel;
	logic                      ref_strobe;
	rom_loader_pkg::mem_addr_t rd_addr;
	logic                      ioctl_wait;
	logic                      mem_wr;
	rom_loader_pkg::mem_req_t  mem_req;
	logic [7:0]                rom_mask;

	logic [3:0]               strobe_cnt;
	logic [31:0]              rng_state;
	int                       errors;
	int                       timeouts;
	int                       commits;
	rom_loader_pkg::mem_req_t seen_q[$];  // Writes seen on the memory side

	`include "rom_loader_model.svh"

	rom_loader_top rom_loader_top_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Refresh pace of one pulse every 16 clocks
	initial begin
		strobe_cnt = '0;
		ref_strobe = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			strobe_cnt = strobe_cnt + 4'd1;
			ref_strobe = (strobe_cnt == 4'd0);
		end
	end

	// The strobe that finds mem_wr high ends the write
	always @(negedge clk_sys) begin
		if (ref_strobe && mem_wr) begin
			if (!ioctl_wait) begin
				errors++;
				$display("mem_wr was high at a ref_strobe while ioctl_wait was low");
			end
			seen_q.push_back(mem_req);
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [7:0] rand_hex();
		logic [31:0] r;
		r = next_rand();
		return (r[3:0] < 4'd10) ? (8'h30 + {4'd0, r[3:0]}) : (8'h37 + {4'd0, r[3:0]});
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_req(input rom_loader_pkg::mem_req_t got,
			input rom_loader_pkg::mem_req_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] mem_req got %h expected %h", got, exp);
		end
	endtask

	task automatic check_mask(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] rom_mask got %h expected %h at rd_addr %h", got, exp, rd_addr);
		end
	endtask

	//////////////////////////////
	// Host side
	//////////////////////////////

	task automatic run_reset(input logic sel_a, input logic sel_b);
		int i;
		reset = 1'b1;
		for (i = 0; i < 10; i++) begin
			model_sel = (i < 5) ? sel_a : sel_b;
			mdl_reset(model_sel);
			@(posedge clk_sys);
			#1;
		end
		reset = 1'b0;
	endtask

	task automatic start_file(input logic [7:0] index, input rom_loader_pkg::file_ext_t ext);
		@(posedge clk_sys);
		#1;
		download    = 1'b1;
		ioctl_index = index;
		file_ext    = ext;
		mdl_start(index, ext);
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic end_file();
		@(posedge clk_sys);
		#1;
		download = 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	// One byte followed by three idle cycles and a wait for ioctl_wait to drop
	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		rom_loader_pkg::mem_req_t exp_req;
		logic                     exp_ok;
		int                       n;
		exp_ok = predict_req(addr, data, ioctl_index, exp_req);
		@(posedge clk_sys);
		#1;
		ioctl_wr   = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		@(posedge clk_sys);
		#1;
		ioctl_wr = 1'b0;
		for (n = 0; n < 3; n++) begin
			@(posedge clk_sys);
			#1;
			if (!exp_ok && ioctl_wait) begin
				errors++;
				$display("ioctl_wait rose for dropped byte at host address %h", addr);
			end
		end
		n = 0;
		while (ioctl_wait && n < 200) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (ioctl_wait) begin
			timeouts++;
			$display("Timed out waiting for ioctl_wait to fall at host address %h", addr);
		end
		if (mem_wr) begin
			errors++;
			$display("mem_wr still high after the write at host address %h", addr);
		end
		if (exp_ok && seen_q.size() == 0) begin
			errors++;
			$display("Missing commit for host address %h", addr);
		end else if (exp_ok) begin
			check_req(seen_q.pop_front(), exp_req);
			mdl_commit(exp_req);
			commits++;
		end
		if (seen_q.size() != 0) begin
			errors++;
			$display("Extra commit after host address %h", addr);
		end
		seen_q.delete();
	endtask

	task automatic send_random(input int count, input logic [24:0] addr_mask);
		logic [31:0] r;
		int          i;
		for (i = 0; i < count; i++) begin
			r = next_rand();
			send_byte(r[24:0] & addr_mask, r[31:24]);
		end
	endtask

	// Sweep all upper pages and then fully random addresses
	task automatic check_masks();
		logic [31:0] r;
		int          p;
		for (p = 0; p < 288; p++) begin
			r = next_rand();
			@(posedge clk_sys);
			#1;
			if (p < 256)
				rd_addr = {1'b1, p[7:0], r[13:0]};
			else
				rd_addr = r[22:0];
			@(negedge clk_sys);
			check_mask(rom_mask, expected_mask(rd_addr));
		end
		@(posedge clk_sys);
		#1;
	endtask

	//////////////////////////////
	// Sequence
	//////////////////////////////

	initial begin
		rom_loader_pkg::file_ext_t ext;
		logic [31:0]               r;
		int                        blk;
		int                        k;
		rng_state   = 32'd26038;
		errors      = 0;
		timeouts    = 0;
		commits     = 0;
		download    = 1'b0;
		ioctl_wr    = 1'b0;
		ioctl_addr  = '0;
		ioctl_dout  = '0;
		ioctl_index = '0;
		file_ext    = '0;
		rd_addr     = '0;
		model_sel   = 1'b1;
		reset       = 1'b1;
		run_reset(1'b1, 1'b0);
		check_masks();
		start_file(8'd0, "SY");  // Blocks 8 to 10 must be dropped
		for (blk = 0; blk < 11; blk++) begin
			for (k = 0; k < 3; k++) begin
				r = next_rand();
				send_byte({blk[10:0], r[13:0]}, r[21:14]);
			end
		end
		end_file();
		for (k = 0; k < 3; k++) begin
			ext.hi = rand_hex();
			ext.lo = rand_hex();
			start_file(8'd3, ext);
			send_random(8, '1);
			end_file();
		end
		check_masks();
		start_file(8'd3, "QX");
		send_random(4, 25'h3FFF);
		end_file();
		start_file(8'd3, "ZZ");
		send_random(4, 25'h3FFF);
		end_file();
		// In a combo file the last offset of page 0 moves the rest to the top page
		start_file(8'd3, "Z0");
		send_random(4, 25'h3FFF);
		r = next_rand();
		send_byte(25'h3FFF, r[7:0]);
		send_random(4, 25'h3FFF);
		end_file();
		check_masks();
		run_reset(1'b0, 1'b0);  // Same model keeps the map
		check_masks();
		run_reset(1'b1, 1'b1);
		check_masks();
		ext.hi = rand_hex();
		ext.lo = rand_hex();
		start_file(8'd5, ext);  // Bank follows the new model
		send_random(6, '1);
		end_file();
		check_masks();
		$display("Checked %0d commits, %0d errors, %0d timeouts", commits, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+source
+incdir+sim
source/rom_loader_pkg.sv
source/ext_page_decode.sv
source/boot_addr_map.sv
source/boot_mem_writer.sv
source/rom_map_table.sv
source/rom_loader_top.sv
sim/tb_rom_loader.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ROM loader testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timescale 1ns/1ps -f filelist.f --top-module tb_rom_loader \
	-Mdir obj_dir -o tb_rom_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_rom_loader > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The testbench prints its fail message on any error or timeout
if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
exit 0
